//--- design/digout_settings.svh
`ifndef DIGOUT_SETTINGS_SVH
`define DIGOUT_SETTINGS_SVH

////////////////////
// Host bus
////////////////////

`define BUS_ADDR_W        8
`define BUS_DATA_W        16

// Two single-ended banks A and B, four outputs each
`define NUM_BANKS         2
`define OUTS_PER_BANK     4

// Field widths inside the bus words
`define FUNC_W            4
`define MODE_W            2
`define RAIL_CODE_W       2

// Three positive and three negative rail switches per bank
`define RAIL_SEL_W        6

// Settling window is 2**RAIL_DELAY_EXP cycles
// Short for simulation, 16 on the board
`define RAIL_DELAY_EXP    4

`define PWM_W             32

////////////////////
// Register addresses
////////////////////

`define ADDR_BANK_A_FUNCT   8'h10
`define ADDR_BANK_B_FUNCT   8'h11
`define ADDR_BANK_A_MODE    8'h12
`define ADDR_BANK_B_MODE    8'h13
`define ADDR_BANK_A_RAILS   8'h14
`define ADDR_BANK_B_RAILS   8'h15
`define ADDR_BANK_AB_STATE  8'h16
`define ADDR_PWM_PERIOD_LO  8'h20
`define ADDR_PWM_PERIOD_HI  8'h21
`define ADDR_PWM_DUTY_LO    8'h22
`define ADDR_PWM_DUTY_HI    8'h23

`endif

//--- design/digout_pkg.sv
`include "digout_settings.svh"

package digout_pkg;

	// Output function, one nibble per output
	// Codes 1 to 9 were halls and encoders, now reserved
	// Any reserved code drives the output low
	typedef enum logic [`FUNC_W-1:0] {
		FUNC_LEVEL = 'd0,
		FUNC_PWM   = 'd10
	} func_code_t;

	// Drive mode of the top and bottom switch pair
	typedef enum logic [`MODE_W-1:0] {
		MODE_PUSH_PULL      = 'd0,
		MODE_OPEN_COLLECTOR = 'd1,
		MODE_OPEN_EMITTER   = 'd2,
		MODE_DISABLED       = 'd3
	} drive_mode_t;

	// Rail choice for one half of a bank
	// Same coding for the positive and the negative half
	typedef enum logic [`RAIL_CODE_W-1:0] {
		RAIL_0    = 'd0,
		RAIL_1    = 'd1,
		RAIL_2    = 'd2,
		// All three switches of the half stay open
		RAIL_NONE = 'd3
	} rail_code_t;

endpackage

//--- design/digout_regs.sv
`include "digout_settings.svh"

module digout_regs
	import digout_pkg::*;
(
	input  logic                                               xclk,
	input  logic                                               reset,
	input  logic                                               write_qualified,
	input  logic [`BUS_ADDR_W-1:0]                             ab,
	input  logic [`BUS_DATA_W-1:0]                             db_in,
	output logic [`NUM_BANKS-1:0][`OUTS_PER_BANK*`FUNC_W-1:0]  bank_funct,
	output logic [`NUM_BANKS-1:0][`OUTS_PER_BANK*`MODE_W-1:0]  bank_mode,
	output logic [`NUM_BANKS-1:0][2*`RAIL_CODE_W-1:0]          bank_rails,
	output logic [`NUM_BANKS*`OUTS_PER_BANK-1:0]               bank_state,
	output logic [`NUM_BANKS-1:0]                              rail_start,
	input  logic [`NUM_BANKS-1:0]                              rail_ack,
	output logic [`PWM_W-1:0]                                  pwm_period,
	output logic [`PWM_W-1:0]                                  pwm_duty,
	output logic                                               pwm_restart
);

	localparam int FUNCT_BITS = `OUTS_PER_BANK * `FUNC_W;
	localparam int MODE_BITS  = `OUTS_PER_BANK * `MODE_W;
	localparam int RAILS_BITS = 2 * `RAIL_CODE_W;
	localparam int STATE_BITS = `NUM_BANKS * `OUTS_PER_BANK;

	// Power-up configuration
	// Every output level, every driver off, no rail connected
	localparam logic [FUNCT_BITS-1:0] FUNCT_RESET = {`OUTS_PER_BANK{FUNC_LEVEL}};
	localparam logic [MODE_BITS-1:0]  MODE_RESET  = {`OUTS_PER_BANK{MODE_DISABLED}};
	localparam logic [RAILS_BITS-1:0] RAILS_RESET = {RAIL_NONE, RAIL_NONE};

	////////////////////
	// Write decode
	////////////////////

	always_ff @(posedge xclk or negedge reset)
	begin
		if (!reset)
		begin
			bank_funct  <= {`NUM_BANKS{FUNCT_RESET}};
			bank_mode   <= {`NUM_BANKS{MODE_RESET}};
			bank_rails  <= {`NUM_BANKS{RAILS_RESET}};
			bank_state  <= '0;
			rail_start  <= '0;
			// Slowest period, half duty
			pwm_period  <= '1;
			pwm_duty    <= {1'b0, {(`PWM_W-1){1'b1}}};
			pwm_restart <= 1'b0;
		end
		else
		begin
			// Restart is a single cycle pulse
			pwm_restart <= 1'b0;
			if (write_qualified)
			begin
				case (ab)
					`ADDR_BANK_A_FUNCT: bank_funct[0] <= db_in[FUNCT_BITS-1:0];
					`ADDR_BANK_B_FUNCT: bank_funct[1] <= db_in[FUNCT_BITS-1:0];
					`ADDR_BANK_A_MODE:  bank_mode[0] <= db_in[MODE_BITS-1:0];
					`ADDR_BANK_B_MODE:  bank_mode[1] <= db_in[MODE_BITS-1:0];
					// New rails also raise the start flag of that bank
					`ADDR_BANK_A_RAILS:
					begin
						bank_rails[0] <= db_in[RAILS_BITS-1:0];
						rail_start[0] <= 1'b1;
					end
					`ADDR_BANK_B_RAILS:
					begin
						bank_rails[1] <= db_in[RAILS_BITS-1:0];
						rail_start[1] <= 1'b1;
					end
					// Bank A levels in the low nibble, bank B above
					`ADDR_BANK_AB_STATE: bank_state <= db_in[STATE_BITS-1:0];
					// PWM values arrive as two halves
					// Each half restarts the generator
					`ADDR_PWM_PERIOD_LO:
					begin
						pwm_period[`BUS_DATA_W-1:0] <= db_in;
						pwm_restart <= 1'b1;
					end
					`ADDR_PWM_PERIOD_HI:
					begin
						pwm_period[`PWM_W-1:`BUS_DATA_W] <= db_in;
						pwm_restart <= 1'b1;
					end
					`ADDR_PWM_DUTY_LO:
					begin
						pwm_duty[`BUS_DATA_W-1:0] <= db_in;
						pwm_restart <= 1'b1;
					end
					`ADDR_PWM_DUTY_HI:
					begin
						pwm_duty[`PWM_W-1:`BUS_DATA_W] <= db_in;
						pwm_restart <= 1'b1;
					end
					// Unknown addresses are ignored
					default: ;
				endcase
			end
			else
			begin
				// Start flag drops once the sequencer acknowledges
				// Only between bus writes
				rail_start <= rail_start & ~rail_ack;
			end
		end
	end

	////////////////////
	// Semaphore check
	////////////////////

	for (genvar b = 0; b < `NUM_BANKS; b++)
	begin : g_start_chk
		// A start request is held until the sequencer has answered
		ap_start_held: assert property (
			@(posedge xclk) disable iff (!reset)
			rail_start[b] && !rail_ack[b] |=> rail_start[b]
		)
		else
			$error("rail_start[%0d] fell without rail_ack", b);
	end

endmodule

//--- design/rail_sequencer.sv
`include "digout_settings.svh"

module rail_sequencer
	import digout_pkg::*;
(
	input  logic                      xclk,
	input  logic                      reset,
	input  logic                      rail_start,
	input  logic [2*`RAIL_CODE_W-1:0] rails,
	output logic                      rail_ack,
	output logic [`RAIL_SEL_W-1:0]    rail_switch
);

	localparam int HALF_W = `RAIL_SEL_W / 2;
	// Top bit of the counter marks the end of the window
	localparam int CNT_W  = `RAIL_DELAY_EXP + 1;

	logic [CNT_W-1:0]       settle_cnt;
	logic [CNT_W-1:0]       settle_next;
	logic [`RAIL_SEL_W-1:0] switch_new;

	// One switch closed per named rail, none for RAIL_NONE
	function automatic logic [HALF_W-1:0] rail_onehot(input rail_code_t code);
		logic [HALF_W-1:0] lines;
		lines = '0;
		case (code)
			RAIL_0:  lines[0] = 1'b1;
			RAIL_1:  lines[1] = 1'b1;
			RAIL_2:  lines[2] = 1'b1;
			default: lines = '0;
		endcase
		return lines;
	endfunction

	assign settle_next = settle_cnt + CNT_W'(1);

	// Positive switches in the low half, negative above
	assign switch_new = {
		rail_onehot(rail_code_t'(rails[2*`RAIL_CODE_W-1:`RAIL_CODE_W])),
		rail_onehot(rail_code_t'(rails[`RAIL_CODE_W-1:0]))
	};

	////////////////////
	// Break before make
	////////////////////

	always_ff @(posedge xclk or negedge reset)
	begin
		if (!reset)
		begin
			settle_cnt  <= '0;
			rail_ack    <= 1'b0;
			rail_switch <= '0;
		end
		else if (rail_start)
		begin
			// Open everything and hold the window at zero
			// A repeated start stretches the window
			rail_switch <= '0;
			rail_ack    <= 1'b1;
			settle_cnt  <= '0;
		end
		else if (rail_ack)
		begin
			settle_cnt <= settle_next;
			// Connect the new rails as the count reaches 2**EXP
			if (settle_next[CNT_W-1])
			begin
				rail_switch <= switch_new;
				rail_ack    <= 1'b0;
			end
		end
	end

	// Two rails of one polarity must never be shorted together
	ap_half_onehot: assert property (
		@(posedge xclk) disable iff (!reset)
		$onehot0(rail_switch[HALF_W-1:0]) && $onehot0(rail_switch[`RAIL_SEL_W-1:HALF_W])
	)
	else
		$error("rail_switch %b closes two rails of one half", rail_switch);

endmodule

//--- design/pwm_gen.sv
`include "digout_settings.svh"

module pwm_gen
(
	input  logic              xclk,
	input  logic              reset,
	input  logic [`PWM_W-1:0] period,
	input  logic [`PWM_W-1:0] duty,
	input  logic              restart,
	output logic              pwm_out
);

	logic [`PWM_W-1:0] count;
	logic [`PWM_W-1:0] count_next;
	// One extra bit so the wrap test holds for any period
	logic [`PWM_W:0]   count_inc;

	assign count_inc = {1'b0, count} + (`PWM_W+1)'(1);

	////////////////////
	// Period counter
	////////////////////

	always_comb
	begin
		// Back to zero on restart or after period-1
		// Period 0 and 1 both keep the count at zero
		if (restart || count_inc >= {1'b0, period})
		begin
			count_next = '0;
		end
		else
		begin
			count_next = count_inc[`PWM_W-1:0];
		end
	end

	always_ff @(posedge xclk or negedge reset)
	begin
		if (!reset)
		begin
			count   <= '0;
			pwm_out <= 1'b0;
		end
		else
		begin
			count <= count_next;
			// Registered compare follows the new count
			// So pwm_out is high exactly while count < duty
			pwm_out <= (count_next < duty);
		end
	end

endmodule

//--- design/bank_driver.sv
`include "digout_settings.svh"

module bank_driver
	import digout_pkg::*;
(
	input  logic [`OUTS_PER_BANK*`FUNC_W-1:0] funct,
	input  logic [`OUTS_PER_BANK*`MODE_W-1:0] mode,
	input  logic [`OUTS_PER_BANK-1:0]         state,
	input  logic                              pwm_out,
	output logic [`OUTS_PER_BANK-1:0]         out_top,
	output logic [`OUTS_PER_BANK-1:0]         out_bot
);

	// Selected function signal per output
	logic [`OUTS_PER_BANK-1:0] sel;

	////////////////////
	// Function select
	////////////////////

	always_comb
	begin
		sel = '0;
		for (int i = 0; i < `OUTS_PER_BANK; i++)
		begin
			// Output 1 sits in the low nibble
			case (func_code_t'(funct[i*`FUNC_W +: `FUNC_W]))
				FUNC_LEVEL: sel[i] = state[i];
				FUNC_PWM:   sel[i] = pwm_out;
				// Reserved codes drive low
				default:    sel[i] = 1'b0;
			endcase
		end
	end

	////////////////////
	// Drive mode
	////////////////////

	always_comb
	begin
		out_top = '0;
		out_bot = '0;
		for (int i = 0; i < `OUTS_PER_BANK; i++)
		begin
			case (drive_mode_t'(mode[i*`MODE_W +: `MODE_W]))
				MODE_PUSH_PULL:
				begin
					out_top[i] = sel[i];
					out_bot[i] = ~sel[i];
				end
				// Sink only
				MODE_OPEN_COLLECTOR:
				begin
					out_bot[i] = ~sel[i];
				end
				// Source only
				MODE_OPEN_EMITTER:
				begin
					out_top[i] = sel[i];
				end
				// Both switches open
				default:
				begin
					out_top[i] = 1'b0;
					out_bot[i] = 1'b0;
				end
			endcase
		end
	end

	// Top and bottom together would short the rails
	always_comb
	begin
		ap_no_shoot_through: assert ((out_top & out_bot) == '0)
		else
			$error("out_top %b and out_bot %b both high", out_top, out_bot);
	end

endmodule

//--- design/digout_top.sv
`include "digout_settings.svh"

module digout_top
(
	input  logic                      xclk,
	input  logic                      reset,
	input  logic                      write_qualified,
	input  logic [`BUS_ADDR_W-1:0]    ab,
	input  logic [`BUS_DATA_W-1:0]    db_in,
	output logic [`OUTS_PER_BANK-1:0] dig_out_a_top,
	output logic [`OUTS_PER_BANK-1:0] dig_out_a_bot,
	output logic [`OUTS_PER_BANK-1:0] dig_out_b_top,
	output logic [`OUTS_PER_BANK-1:0] dig_out_b_bot,
	output logic [`RAIL_SEL_W-1:0]    do_rails_a,
	output logic [`RAIL_SEL_W-1:0]    do_rails_b
);

	// Configuration held by the register block
	logic [`NUM_BANKS-1:0][`OUTS_PER_BANK*`FUNC_W-1:0] bank_funct;
	logic [`NUM_BANKS-1:0][`OUTS_PER_BANK*`MODE_W-1:0] bank_mode;
	logic [`NUM_BANKS-1:0][2*`RAIL_CODE_W-1:0]         bank_rails;
	logic [`NUM_BANKS*`OUTS_PER_BANK-1:0]              bank_state;

	// Rail start and acknowledge per bank
	logic [`NUM_BANKS-1:0] rail_start;
	logic [`NUM_BANKS-1:0] rail_ack;

	// PWM settings and the shared PWM signal
	logic [`PWM_W-1:0]     pwm_period;
	logic [`PWM_W-1:0]     pwm_duty;
	logic                  pwm_restart;
	logic                  pwm_out;

	digout_regs regs_i (
		.xclk            (xclk),
		.reset           (reset),
		.write_qualified (write_qualified),
		.ab              (ab),
		.db_in           (db_in),
		.bank_funct      (bank_funct),
		.bank_mode       (bank_mode),
		.bank_rails      (bank_rails),
		.bank_state      (bank_state),
		.rail_start      (rail_start),
		.rail_ack        (rail_ack),
		.pwm_period      (pwm_period),
		.pwm_duty        (pwm_duty),
		.pwm_restart     (pwm_restart)
	);

	////////////////////
	// Rail switches
	////////////////////

	rail_sequencer rails_a_i (
		.xclk        (xclk),
		.reset       (reset),
		.rail_start  (rail_start[0]),
		.rails       (bank_rails[0]),
		.rail_ack    (rail_ack[0]),
		.rail_switch (do_rails_a)
	);

	rail_sequencer rails_b_i (
		.xclk        (xclk),
		.reset       (reset),
		.rail_start  (rail_start[1]),
		.rails       (bank_rails[1]),
		.rail_ack    (rail_ack[1]),
		.rail_switch (do_rails_b)
	);

	// One PWM source shared by every output
	pwm_gen pwm_i (
		.xclk    (xclk),
		.reset   (reset),
		.period  (pwm_period),
		.duty    (pwm_duty),
		.restart (pwm_restart),
		.pwm_out (pwm_out)
	);

	////////////////////
	// Output banks
	////////////////////

	bank_driver bank_a_i (
		.funct   (bank_funct[0]),
		.mode    (bank_mode[0]),
		.state   (bank_state[`OUTS_PER_BANK-1:0]),
		.pwm_out (pwm_out),
		.out_top (dig_out_a_top),
		.out_bot (dig_out_a_bot)
	);

	bank_driver bank_b_i (
		.funct   (bank_funct[1]),
		.mode    (bank_mode[1]),
		.state   (bank_state[2*`OUTS_PER_BANK-1:`OUTS_PER_BANK]),
		.pwm_out (pwm_out),
		.out_top (dig_out_b_top),
		.out_bot (dig_out_b_bot)
	);

endmodule

//--- test/digout_tb.sv
`include "digout_settings.svh"

module digout_tb;

	localparam int MAX_CMDS = 256;

	// DUT inputs
	logic                      xclk = 1'b0;
	logic                      reset;
	logic                      write_qualified;
	logic [`BUS_ADDR_W-1:0]    ab;
	logic [`BUS_DATA_W-1:0]    db_in;

	// DUT outputs
	logic [`OUTS_PER_BANK-1:0] dig_out_a_top;
	logic [`OUTS_PER_BANK-1:0] dig_out_a_bot;
	logic [`OUTS_PER_BANK-1:0] dig_out_b_top;
	logic [`OUTS_PER_BANK-1:0] dig_out_b_bot;
	logic [`RAIL_SEL_W-1:0]    do_rails_a;
	logic [`RAIL_SEL_W-1:0]    do_rails_b;

	// Parsed command table
	logic [7:0]  op_q [MAX_CMDS];
	logic [63:0] grp_q [MAX_CMDS];
	logic [31:0] arg1_q [MAX_CMDS];
	logic [31:0] arg2_q [MAX_CMDS];
	logic [31:0] arg3_q [MAX_CMDS];
	int          n_cmds;
	bit          loaded;

	digout_top dut_i (
		.xclk            (xclk),
		.reset           (reset),
		.write_qualified (write_qualified),
		.ab              (ab),
		.db_in           (db_in),
		.dig_out_a_top   (dig_out_a_top),
		.dig_out_a_bot   (dig_out_a_bot),
		.dig_out_b_top   (dig_out_b_top),
		.dig_out_b_bot   (dig_out_b_bot),
		.do_rails_a      (do_rails_a),
		.do_rails_b      (do_rails_b)
	);

	// 4 unit period
	always #2 xclk = ~xclk;

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	////////////////////
	// Test file parsing
	////////////////////

	task automatic load_tests();
		int               fd;
		int               r;
		int               need;
		logic [63:0]      tok;
		logic [63:0]      g;
		logic [31:0]      a1;
		logic [31:0]      a2;
		logic [31:0]      a3;
		logic [8*160-1:0] rest;
		fd = $fopen("test/digout_tests.txt", "r");
		assert (fd != 0) else report_error("cannot open test/digout_tests.txt");
		n_cmds = 0;
		while (!$feof(fd))
		begin
			tok = '0;
			r = $fscanf(fd, "%s", tok);
			if (r == 1)
			begin
				// Comment lines start with a lone hash
				if (tok == "#")
				begin
					r = $fgets(rest, fd);
				end
				else
				begin
					g = '0;
					a1 = '0;
					a2 = '0;
					a3 = '0;
					case (tok)
						"W", "C": r = $fscanf(fd, "%s %h", g, a1);
						"R":      r = $fscanf(fd, "%h %h", a1, a2);
						"I":      r = $fscanf(fd, "%d", a1);
						"T":      r = $fscanf(fd, "%s %h %d", g, a1, a2);
						"P":      r = $fscanf(fd, "%s %d %d %d", g, a1, a2, a3);
						default:  report_error("unknown command in test file");
					endcase
					// Fields expected after the command letter
					case (tok)
						"I":     need = 1;
						"T":     need = 3;
						"P":     need = 4;
						default: need = 2;
					endcase
					assert (r == need) else report_error("malformed line in test file");
					assert (n_cmds < MAX_CMDS) else report_error("too many commands in test file");
					op_q[n_cmds] = tok[7:0];
					grp_q[n_cmds] = g;
					arg1_q[n_cmds] = a1;
					arg2_q[n_cmds] = a2;
					arg3_q[n_cmds] = a3;
					n_cmds++;
				end
			end
		end
		$fclose(fd);
	endtask

	// Register names of the test file, mapped to bus addresses
	function automatic int reg_address(input logic [63:0] name);
		case (name)
			"A_FUNCT": return int'(`ADDR_BANK_A_FUNCT);
			"B_FUNCT": return int'(`ADDR_BANK_B_FUNCT);
			"A_MODE":  return int'(`ADDR_BANK_A_MODE);
			"B_MODE":  return int'(`ADDR_BANK_B_MODE);
			"A_RAILS": return int'(`ADDR_BANK_A_RAILS);
			"B_RAILS": return int'(`ADDR_BANK_B_RAILS);
			"STATE":   return int'(`ADDR_BANK_AB_STATE);
			"PER_LO":  return int'(`ADDR_PWM_PERIOD_LO);
			"PER_HI":  return int'(`ADDR_PWM_PERIOD_HI);
			"DUTY_LO": return int'(`ADDR_PWM_DUTY_LO);
			"DUTY_HI": return int'(`ADDR_PWM_DUTY_HI);
			default:   return -1;
		endcase
	endfunction

	////////////////////
	// Bus and sampling
	////////////////////

	// Called 1 unit after an edge
	// Returns 1 unit after the write edge
	task automatic bus_write(input logic [`BUS_ADDR_W-1:0] addr,
		input logic [`BUS_DATA_W-1:0] data);
		write_qualified = 1'b1;
		ab = addr;
		db_in = data;
		@(posedge xclk);
		#1;
		write_qualified = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge xclk);
			#1;
		end
	endtask

	task automatic read_group(input logic [63:0] grp, output logic [31:0] val,
		output string name);
		val = '0;
		case (grp)
			"a_top":   val = 32'(dig_out_a_top);
			"a_bot":   val = 32'(dig_out_a_bot);
			"b_top":   val = 32'(dig_out_b_top);
			"b_bot":   val = 32'(dig_out_b_bot);
			"rails_a": val = 32'(do_rails_a);
			"rails_b": val = 32'(do_rails_b);
			default:   report_error("unknown output group in test file");
		endcase
		// Port name shown in error lines
		case (grp)
			"a_top":   name = "dig_out_a_top";
			"a_bot":   name = "dig_out_a_bot";
			"b_top":   name = "dig_out_b_top";
			"b_bot":   name = "dig_out_b_bot";
			"rails_a": name = "do_rails_a";
			"rails_b": name = "do_rails_b";
			default:   name = "";
		endcase
	endtask

	task automatic check_group(input logic [63:0] grp, input logic [31:0] exp);
		logic [31:0] got;
		string       name;
		read_group(grp, got, name);
		assert (got == exp)
		else
			report_error($sformatf("ERR %s got %h exp %h", name, got, exp));
	endtask

	// Poll once per cycle until the group shows the value
	task automatic wait_group(input logic [63:0] grp, input logic [31:0] exp, input int max);
		logic [31:0] got;
		string       name;
		int          waited;
		waited = 0;
		read_group(grp, got, name);
		while (got != exp && waited < max)
		begin
			@(posedge xclk);
			#1;
			waited++;
			read_group(grp, got, name);
		end
		assert (got == exp)
		else
			report_error($sformatf("%s did not reach %h within %0d cycles", name, exp, max));
	endtask

	// High cycles of one output bit over a window of cycles
	task automatic count_high(input logic [63:0] grp, input int bitn, input int win,
		input int exp);
		logic [31:0] got;
		string       name;
		int          high;
		high = 0;
		for (int c = 0; c < win; c++)
		begin
			read_group(grp, got, name);
			if (got[bitn])
				high++;
			@(posedge xclk);
			#1;
		end
		assert (high == exp)
		else
			report_error($sformatf("ERR %s[%0d] high count got %h exp %h",
				name, bitn, high, exp));
	endtask

	task automatic run_command(input int idx);
		int addr;
		case (op_q[idx])
			"W":
			begin
				addr = reg_address(grp_q[idx]);
				assert (addr >= 0) else report_error("unknown register name in test file");
				bus_write(addr[`BUS_ADDR_W-1:0], arg1_q[idx][`BUS_DATA_W-1:0]);
			end
			"R": bus_write(arg1_q[idx][`BUS_ADDR_W-1:0], arg2_q[idx][`BUS_DATA_W-1:0]);
			"I": idle_cycles(int'(arg1_q[idx]));
			"C": check_group(grp_q[idx], arg1_q[idx]);
			"T": wait_group(grp_q[idx], arg1_q[idx], int'(arg2_q[idx]));
			"P": count_high(grp_q[idx], int'(arg1_q[idx]), int'(arg2_q[idx]),
				int'(arg3_q[idx]));
			default: report_error("unknown command in test file");
		endcase
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial
	begin
		reset = 1'b0;
		write_qualified = 1'b0;
		ab = '0;
		db_in = '0;
		loaded = 1'b0;
		load_tests();
		loaded = 1'b1;
		// Reset held for 10 cycles
		repeat (10) @(posedge xclk);
		#1;
		reset = 1'b1;
		for (int i = 0; i < n_cmds; i++)
			run_command(i);
		$display("Simulation passed");
		$finish;
	end

	// Budget per command covers one full rail window plus margin
	initial
	begin : watchdog
		int limit;
		wait (loaded);
		limit = (n_cmds * ((1 << `RAIL_DELAY_EXP) + 40) + 10) * 4;
		#(limit);
		$display("Watchdog timeout after %0d time units, the tests did not finish", limit);
		$display("Simulation failed");
		$fatal(1);
	end

endmodule

//--- test/digout_tests.txt
# W reg data | R addr data | I cycles | C group hex | T group hex max_cycles
# P group bit window high_count, groups are a_top a_bot b_top b_bot rails_a rails_b
# After reset every output and rail switch is off
C a_top 0
C a_bot 0
C b_top 0
C b_bot 0
C rails_a 00
C rails_b 00
# Bank A level function, A1 push-pull A2 open collector A3 open emitter A4 off
W A_MODE 00E4
W STATE 000F
C a_top 5
C a_bot 0
W STATE 0000
C a_top 0
C a_bot 3
# Modes rotated, A1 off A2 open emitter A3 open collector A4 push-pull
W A_MODE 001B
W STATE 000F
C a_top A
C a_bot 0
W STATE 0000
C a_top 0
C a_bot C
# All push-pull with a mixed pattern
W A_MODE 0000
W STATE 0005
C a_top 5
C a_bot A
# Reserved function code 5 on A1 acts as level 0
W A_FUNCT 0005
W STATE 000F
C a_top E
C a_bot 1
# Bank B levels sit in state bits 7:4
W B_MODE 0000
W STATE 0050
C b_top 5
C b_bot A
C a_top 0
C a_bot F
# Reserved code 15 on B4
W B_FUNCT F000
W STATE 00F0
C b_top 7
C b_bot 8
# Unknown addresses change nothing
R 30 FFFF
R 17 0000
C a_top 0
C b_top 7
C b_bot 8
# Bank B rails, positive rail 2 and negative rail 1
W B_RAILS 0006
T rails_b 14 24
# Bank A rails, positive rail 0 and negative rail 1
W A_RAILS 0004
T rails_a 11 24
C rails_b 14
# Bank A to positive rail 1 and negative rail 2
W A_RAILS 0009
T rails_a 00 3
C rails_b 14
T rails_a 22 24
C rails_b 14
# Negative half to none
W A_RAILS 000C
T rails_a 00 3
T rails_a 01 24
# A second write inside the open window restarts it
W A_RAILS 0005
I 10
W A_RAILS 0006
I 10
C rails_a 00
T rails_a 14 24
# Bank B to none on both halves
W B_RAILS 000F
T rails_b 00 3
I 20
C rails_b 00
C rails_a 14
# PWM period 10 duty 3 on B2 in push-pull
W PER_LO 000A
W PER_HI 0000
W DUTY_LO 0003
W DUTY_HI 0000
W B_FUNCT 00A0
W B_MODE 00F3
I 2
P b_top 1 10 3
P b_bot 1 10 7
I 3
P b_top 1 10 3
I 7
P b_bot 1 10 7
P b_top 0 10 0
P b_bot 0 10 0
C a_top 0

//--- project.f
+incdir+design
design/digout_pkg.sv
design/digout_regs.sv
design/rail_sequencer.sv
design/pwm_gen.sv
design/bank_driver.sv
design/digout_top.sv
test/digout_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module digout_tb \
	-f project.f -o digout_sim > sim.log 2>&1 &&
	./obj_dir/digout_sim >> sim.log 2>&1 ||
	echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
